// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int PC_W       = 32;
    localparam int ALUSEL_W   = 3;

    // register and data word
    typedef logic [WORD_W-1:0] word_t;

    // register file index
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [PC_W-1:0] pc_t;

    // which unit produced the result in EX
    typedef logic [ALUSEL_W-1:0] alusel_t;

    localparam alusel_t EXE_RES_NOP        = 3'b000;
    localparam alusel_t EXE_RES_LOGIC      = 3'b001;
    localparam alusel_t EXE_RES_SHIFT      = 3'b010;
    localparam alusel_t EXE_RES_ARITH      = 3'b100;
    localparam alusel_t EXE_RES_LOAD_STORE = 3'b111; // only code the mem stage acts on

    // x0, writes here are dropped
    localparam reg_addr_t NOP_REG_ADDR = 5'd0;

    localparam word_t ZERO_WORD = 32'h0000_0000;

endpackage

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int MEM_ADDR_W = 32;

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t; // byte address
    typedef logic [7:0]            mem_byte_t;
    typedef logic [1:0]            mem_sel_t;
    typedef logic [2:0]            byte_cnt_t; // 0..4 bytes

    localparam mem_sel_t MEM_NOP  = 2'b00;
    localparam mem_sel_t MEM_BYTE = 2'b01;
    localparam mem_sel_t MEM_HALF = 2'b10;
    localparam mem_sel_t MEM_WORD = 2'b11;

    typedef enum logic [2:0] {
        IDLE,
        STORE,
        LOAD_ADDR,
        LOAD_DATA,
        DONE
    } access_state_t;

    // bytes moved for one access
    function automatic byte_cnt_t sel_bytes(input mem_sel_t sel);
        byte_cnt_t n;
        case (sel)
            MEM_BYTE: n = 3'd1;
            MEM_HALF: n = 3'd2;
            MEM_WORD: n = 3'd4;
            default:  n = 3'd0;
        endcase
        return n;
    endfunction

endpackage

`default_nettype wire

// File: hdl/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access (
    input  wire                      clk,
    input  wire                      rst,
    // held EX/MEM fields
    input  wire cpu_pkg::reg_addr_t  rd_i,
    input  wire cpu_pkg::word_t      wdata_i,
    input  wire                      wreg_i,
    input  wire cpu_pkg::pc_t        pc_i,
    input  wire cpu_pkg::word_t      reg2_i,      // store data
    input  wire mem_pkg::mem_addr_t  mem_addr_i,
    input  wire cpu_pkg::alusel_t    alusel_i,
    input  wire mem_pkg::mem_sel_t   mem_sel_i,
    input  wire                      mem_we_i,
    input  wire                      load_sign_i,
    // byte RAM
    input  wire mem_pkg::mem_byte_t  ram_rbyte_i,
    output mem_pkg::mem_addr_t       ram_addr_o,
    output logic                     ram_we_o,
    output mem_pkg::mem_byte_t       ram_wbyte_o,
    // pipeline
    output logic                     stall_o,
    output cpu_pkg::reg_addr_t       rd_o,
    output cpu_pkg::word_t           wdata_o,
    output logic                     wreg_o,
    output cpu_pkg::pc_t             pc_o
);
    import cpu_pkg::*;
    import mem_pkg::*;

    access_state_t state;
    byte_cnt_t     cnt;        // bytes whose address has been issued
    byte_cnt_t     nbytes;
    word_t         load_word;
    word_t         load_ext;
    logic          is_mem;
    logic          is_load;
    logic          capture;
    logic [1:0]    cap_idx;
    logic [1:0]    wr_idx;

    assign nbytes  = sel_bytes(mem_sel_i);
    assign is_mem  = (alusel_i == EXE_RES_LOAD_STORE) && (mem_sel_i != MEM_NOP);
    assign is_load = is_mem && !mem_we_i;

    // DONE drops the stall so the driver moves on
    assign stall_o = is_mem && (state != DONE);

    // read data trails its address by one cycle
    assign capture = ((state == LOAD_ADDR) && (cnt > 3'd1)) || (state == LOAD_DATA);
    assign cap_idx = (state == LOAD_DATA) ? 2'(nbytes - 3'd1) : 2'(cnt - 3'd2);
    assign wr_idx  = cnt[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            cnt        <= '0;
            ram_we_o   <= 1'b0;
            ram_addr_o <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (is_mem) begin
                        ram_addr_o <= mem_addr_i; // first byte at base
                        ram_we_o   <= mem_we_i;
                        cnt        <= 3'd1;
                        state      <= mem_we_i ? STORE : LOAD_ADDR;
                    end
                end
                STORE: begin
                    if (cnt == nbytes) begin
                        ram_we_o <= 1'b0;
                        state    <= DONE;
                    end else begin
                        ram_addr_o <= mem_addr_i + mem_addr_t'(cnt);
                        cnt        <= cnt + 3'd1;
                    end
                end
                LOAD_ADDR: begin
                    if (cnt == nbytes) begin
                        state <= LOAD_DATA; // last byte still in flight
                    end else begin
                        ram_addr_o <= mem_addr_i + mem_addr_t'(cnt);
                        cnt        <= cnt + 3'd1;
                    end
                end
                LOAD_DATA: begin
                    state <= DONE;
                end
                DONE: begin
                    state <= IDLE; // pipeline advances on this edge
                    cnt   <= '0;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // store byte follows the address register
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            ram_wbyte_o <= reg2_i[7:0];
        end else if (state == STORE) begin
            ram_wbyte_o <= reg2_i[8*wr_idx +: 8];
        end
    end

    // load assembly, little endian
    always_ff @(posedge clk) begin
        if (capture) begin
            load_word[8*cap_idx +: 8] <= ram_rbyte_i;
        end
    end

    always_comb begin
        case (mem_sel_i)
            MEM_BYTE: begin
                if (load_sign_i) begin
                    load_ext = {{24{load_word[7]}}, load_word[7:0]};
                end else begin
                    load_ext = {24'h00_0000, load_word[7:0]};
                end
            end
            MEM_HALF: begin
                if (load_sign_i) begin
                    load_ext = {{16{load_word[15]}}, load_word[15:0]};
                end else begin
                    load_ext = {16'h0000, load_word[15:0]};
                end
            end
            default: load_ext = load_word;
        endcase
    end

    assign wdata_o = is_load ? load_ext : wdata_i;
    assign rd_o    = rd_i;
    assign wreg_o  = wreg_i;
    assign pc_o    = pc_i;

    // write strobe belongs to the store walk only
    a_we_in_store: assert property (
        @(posedge clk) disable iff (rst)
        ram_we_o |-> (state == STORE)
    );

    // word load is the longest access at 6 cycles
    a_stall_bound: assert property (
        @(posedge clk) disable iff (rst)
        not (stall_o [*7])
    );

    // upstream must hold the instruction while stalled
    a_sel_held: assert property (
        @(posedge clk) disable iff (rst)
        stall_o |=> $stable(mem_sel_i)
    );

endmodule

`default_nettype wire

// File: hdl/byte_ram.sv
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
    parameter int ADDR_W = 10
) (
    input  wire                      clk,
    input  wire                      we_i,
    input  wire mem_pkg::mem_addr_t  addr_i,
    input  wire mem_pkg::mem_byte_t  wbyte_i,
    output mem_pkg::mem_byte_t       rbyte_o
);
    import mem_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    mem_byte_t          mem_q [DEPTH];
    logic [ADDR_W-1:0]  idx;

    assign idx = addr_i[ADDR_W-1:0]; // upper bits ignored

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[idx] <= wbyte_i;
        end
    end

    // old data on a same-address write
    always_ff @(posedge clk) begin
        rbyte_o <= mem_q[idx];
    end

    // a store outside the array would alias onto a low address
    a_addr_in_range: assert property (
        @(posedge clk)
        we_i |-> ((addr_i >> ADDR_W) == '0)
    );

endmodule

`default_nettype wire

// File: hdl/mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      hold_i,   // stage stalled
    input  wire cpu_pkg::reg_addr_t  rd_i,
    input  wire cpu_pkg::word_t      wdata_i,
    input  wire                      wreg_i,
    input  wire cpu_pkg::pc_t        pc_i,
    output cpu_pkg::reg_addr_t       rd_o,
    output cpu_pkg::word_t           wdata_o,
    output logic                     wreg_o,
    output cpu_pkg::pc_t             pc_o
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_o    <= NOP_REG_ADDR;
            wdata_o <= ZERO_WORD;
            wreg_o  <= 1'b0;
            pc_o    <= '0;
        end else if (hold_i) begin
            // bubble, pc left as is
            rd_o    <= NOP_REG_ADDR;
            wdata_o <= ZERO_WORD;
            wreg_o  <= 1'b0;
        end else begin
            rd_o    <= rd_i;
            wdata_o <= wdata_i;
            wreg_o  <= wreg_i;
            pc_o    <= pc_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top #(
    parameter int ADDR_W = 10
) (
    input  wire                      clk,
    input  wire                      rst,
    // EX/MEM register
    input  wire cpu_pkg::reg_addr_t  rd_i,
    input  wire cpu_pkg::word_t      wdata_i,
    input  wire                      wreg_i,
    input  wire cpu_pkg::pc_t        pc_i,
    input  wire cpu_pkg::word_t      reg2_i,
    input  wire mem_pkg::mem_addr_t  mem_addr_i,
    input  wire cpu_pkg::alusel_t    alusel_i,
    input  wire mem_pkg::mem_sel_t   mem_sel_i,
    input  wire                      mem_we_i,
    input  wire                      load_sign_i,
    output logic                     stall_o,
    // writeback
    output cpu_pkg::reg_addr_t       wb_rd_o,
    output cpu_pkg::word_t           wb_wdata_o,
    output logic                     wb_wreg_o,
    output cpu_pkg::pc_t             wb_pc_o
);
    import cpu_pkg::*;
    import mem_pkg::*;

    mem_addr_t  ram_addr;
    logic       ram_we;
    mem_byte_t  ram_wbyte;
    mem_byte_t  ram_rbyte;

    reg_addr_t  ma_rd;
    word_t      ma_wdata;
    logic       ma_wreg;
    pc_t        ma_pc;

    mem_access u_mem_access (
        .clk         (clk),
        .rst         (rst),
        .rd_i        (rd_i),
        .wdata_i     (wdata_i),
        .wreg_i      (wreg_i),
        .pc_i        (pc_i),
        .reg2_i      (reg2_i),
        .mem_addr_i  (mem_addr_i),
        .alusel_i    (alusel_i),
        .mem_sel_i   (mem_sel_i),
        .mem_we_i    (mem_we_i),
        .load_sign_i (load_sign_i),
        .ram_rbyte_i (ram_rbyte),
        .ram_addr_o  (ram_addr),
        .ram_we_o    (ram_we),
        .ram_wbyte_o (ram_wbyte),
        .stall_o     (stall_o),
        .rd_o        (ma_rd),
        .wdata_o     (ma_wdata),
        .wreg_o      (ma_wreg),
        .pc_o        (ma_pc)
    );

    byte_ram #(
        .ADDR_W (ADDR_W)
    ) u_byte_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .wbyte_i (ram_wbyte),
        .rbyte_o (ram_rbyte)
    );

    // stall turns the MEM/WB load into a bubble
    mem_wb_reg u_mem_wb_reg (
        .clk     (clk),
        .rst     (rst),
        .hold_i  (stall_o),
        .rd_i    (ma_rd),
        .wdata_i (ma_wdata),
        .wreg_i  (ma_wreg),
        .pc_i    (ma_pc),
        .rd_o    (wb_rd_o),
        .wdata_o (wb_wdata_o),
        .wreg_o  (wb_wreg_o),
        .pc_o    (wb_pc_o)
    );

endmodule

`default_nettype wire

// File: sim/tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;
    import cpu_pkg::*;
    import mem_pkg::*;

    localparam int          ADDR_W         = 10;
    localparam int          RAM_BYTES      = 1 << ADDR_W;
    localparam int          CLK_PERIOD     = 10;
    localparam int          STALL_LIMIT    = 16;
    localparam int          N_TESTS        = 6;
    localparam int          MAX_INSTR      = 64;  // per test, upper bound
    localparam int          TIMEOUT_CYCLES = N_TESTS * MAX_INSTR * 8 + 200;
    localparam logic [31:0] SEED           = 32'hfc66_a854;
    localparam mem_addr_t   MIX_BASE       = 32'h0000_0300;

    logic       clk;
    logic       rst;
    reg_addr_t  rd_i;
    word_t      wdata_i;
    logic       wreg_i;
    pc_t        pc_i;
    word_t      reg2_i;
    mem_addr_t  mem_addr_i;
    alusel_t    alusel_i;
    mem_sel_t   mem_sel_i;
    logic       mem_we_i;
    logic       load_sign_i;
    logic       stall_o;
    reg_addr_t  wb_rd_o;
    word_t      wb_wdata_o;
    logic       wb_wreg_o;
    pc_t        wb_pc_o;

    mem_byte_t  ref_mem [RAM_BYTES];  // reference copy of the RAM
    pc_t        next_pc;
    string      test_name;
    int         value_errs;
    int         proto_errs;
    logic       count_wb;
    int         wb_seen;
    int         wb_expected;

    mem_stage_top #(
        .ADDR_W (ADDR_W)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .rd_i        (rd_i),
        .wdata_i     (wdata_i),
        .wreg_i      (wreg_i),
        .pc_i        (pc_i),
        .reg2_i      (reg2_i),
        .mem_addr_i  (mem_addr_i),
        .alusel_i    (alusel_i),
        .mem_sel_i   (mem_sel_i),
        .mem_we_i    (mem_we_i),
        .load_sign_i (load_sign_i),
        .stall_o     (stall_o),
        .wb_rd_o     (wb_rd_o),
        .wb_wdata_o  (wb_wdata_o),
        .wb_wreg_o   (wb_wreg_o),
        .wb_pc_o     (wb_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    // writeback pulses, mid cycle
    always @(negedge clk) begin
        if (count_wb && wb_wreg_o === 1'b1) begin
            wb_seen++;
        end
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(input string what, input reg_addr_t exp, input reg_addr_t act);
        if (act !== exp) begin
            value_errs++;
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            value_errs++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            value_errs++;
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    function automatic int access_len(input mem_sel_t sel);
        case (sel)
            MEM_BYTE: return 1;
            MEM_HALF: return 2;
            MEM_WORD: return 4;
            default:  return 0;
        endcase
    endfunction

    // little endian, upper bits zero unless sign filled
    function automatic word_t expected_load(input mem_addr_t addr, input mem_sel_t sel,
                                            input logic sign);
        word_t w;
        w = 32'h0;
        for (int k = 0; k < access_len(sel); k++) begin
            w[8*k +: 8] = ref_mem[addr + k];
        end
        if (sign && sel == MEM_BYTE) begin
            w[31:8] = {24{w[7]}};
        end
        if (sign && sel == MEM_HALF) begin
            w[31:16] = {16{w[15]}};
        end
        return w;
    endfunction

    function automatic reg_addr_t random_rd();
        return reg_addr_t'($urandom_range(1, 31));
    endfunction

    // one instruction through the stage, called 1 ns after a rising edge
    task automatic present_instr(input alusel_t alusel, input mem_sel_t sel, input logic we,
                                 input logic sign, input mem_addr_t addr, input word_t sdata,
                                 input reg_addr_t rd, input word_t alu_res, input logic wreg,
                                 input word_t exp_wdata, input int exp_stall);
        pc_t pc;
        int  stalled;
        pc          = next_pc;
        next_pc     = next_pc + 32'd4;
        alusel_i    = alusel;
        mem_sel_i   = sel;
        mem_we_i    = we;
        load_sign_i = sign;
        mem_addr_i  = addr;
        reg2_i      = sdata;
        rd_i        = rd;
        wdata_i     = alu_res;
        wreg_i      = wreg;
        pc_i        = pc;
        if (wreg && count_wb) begin
            wb_expected++;
        end
        stalled = 0;
        @(negedge clk);
        while (stall_o !== 1'b0 && stalled < STALL_LIMIT) begin
            if (stalled > 0) begin
                check_bit("bubble wreg", 1'b0, wb_wreg_o);
            end
            stalled++;
            @(negedge clk);
        end
        if (stalled == STALL_LIMIT) begin
            proto_errs++;
            $display("%s: stall_o stayed high for %0d cycles at pc %h", test_name, stalled, pc);
        end
        check_count("stall cycles", exp_stall, stalled);
        @(posedge clk);  // stage advances here
        #1;
        check_reg("wb rd", rd, wb_rd_o);
        check_word("wb wdata", exp_wdata, wb_wdata_o);
        check_bit("wb wreg", wreg, wb_wreg_o);
        check_word("wb pc", pc, wb_pc_o);
        alusel_i  = EXE_RES_NOP;  // empty slot
        mem_sel_i = MEM_NOP;
        mem_we_i  = 1'b0;
        wreg_i    = 1'b0;
        rd_i      = NOP_REG_ADDR;
    endtask

    task automatic alu_op(input reg_addr_t rd, input word_t res);
        alusel_t sel;
        case ($urandom_range(0, 2))
            0:       sel = EXE_RES_LOGIC;
            1:       sel = EXE_RES_SHIFT;
            default: sel = EXE_RES_ARITH;
        endcase
        present_instr(sel, MEM_NOP, 1'b0, 1'b0, 32'h0, $urandom, rd, res, 1'b1, res, 0);
    endtask

    task automatic store_op(input mem_sel_t sel, input mem_addr_t addr, input word_t data);
        present_instr(EXE_RES_LOAD_STORE, sel, 1'b1, 1'b0, addr, data, NOP_REG_ADDR, addr,
                      1'b0, addr, access_len(sel) + 1);
        for (int k = 0; k < access_len(sel); k++) begin
            ref_mem[addr + k] = data[8*k +: 8];
        end
    endtask

    task automatic load_op(input mem_sel_t sel, input logic sign, input reg_addr_t rd,
                           input mem_addr_t addr, input word_t exp);
        present_instr(EXE_RES_LOAD_STORE, sel, 1'b0, sign, addr, $urandom, rd, addr, 1'b1,
                      exp, access_len(sel) + 2);
    endtask

    task automatic reset_values();
        test_name = "reset";
        check_bit("stall", 1'b0, stall_o);
        check_bit("wb wreg", 1'b0, wb_wreg_o);
        check_reg("wb rd", NOP_REG_ADDR, wb_rd_o);
        check_word("wb wdata", 32'h0, wb_wdata_o);
        check_word("wb pc", 32'h0, wb_pc_o);
    endtask

    task automatic alu_passthrough();
        test_name = "alu_passthrough";
        for (int i = 0; i < 16; i++) begin
            alu_op(random_rd(), $urandom);
        end
    endtask

    task automatic word_round_trip();
        mem_addr_t addrs [8];
        word_t     words [8];
        test_name = "word_round_trip";
        for (int i = 0; i < 8; i++) begin
            addrs[i] = mem_addr_t'(($urandom_range(0, 31) * 8 + i) * 4); // distinct words
            words[i] = $urandom;
            store_op(MEM_WORD, addrs[i], words[i]);
        end
        for (int i = 0; i < 8; i++) begin
            load_op(MEM_WORD, 1'b0, random_rd(), addrs[i], words[i]);
        end
    endtask

    task automatic store_isolation();
        mem_addr_t base;
        mem_sel_t  sel;
        int        off;
        test_name = "store_isolation";
        for (int i = 0; i < 8; i++) begin
            base = mem_addr_t'($urandom_range(0, 255) * 4);
            store_op(MEM_WORD, base, $urandom);
            if ($urandom_range(0, 1) == 0) begin
                sel = MEM_BYTE;
                off = $urandom_range(0, 3);
            end else begin
                sel = MEM_HALF;
                off = 2 * $urandom_range(0, 1);
            end
            store_op(sel, base + off, $urandom);
            load_op(MEM_WORD, 1'b0, random_rd(), base, expected_load(base, MEM_WORD, 1'b0));
        end
    endtask

    task automatic load_extension();
        mem_addr_t addr;
        mem_sel_t  sel;
        word_t     pattern;
        word_t     zext;
        word_t     sext;
        test_name = "load_extension";
        for (int s = 0; s < 2; s++) begin
            for (int top = 0; top < 2; top++) begin
                sel     = (s == 0) ? MEM_BYTE : MEM_HALF;
                addr    = 32'h0000_0380 + 4 * (2 * s + top);
                pattern = $urandom;
                pattern[(s == 0) ? 7 : 15] = top[0];  // top bit of the loaded part
                store_op(MEM_WORD, addr, pattern);
                if (s == 0) begin
                    zext = {24'h00_0000, pattern[7:0]};
                    sext = top ? {24'hff_ffff, pattern[7:0]} : zext;
                end else begin
                    zext = {16'h0000, pattern[15:0]};
                    sext = top ? {16'hffff, pattern[15:0]} : zext;
                end
                load_op(sel, 1'b1, random_rd(), addr, sext);
                load_op(sel, 1'b0, random_rd(), addr, zext);
            end
        end
    endtask

    task automatic mixed_sequence();
        int        kind;
        mem_sel_t  sel;
        mem_addr_t addr;
        logic      sign;
        test_name = "mixed_sequence";
        @(posedge clk);
        #1;
        wb_seen     = 0;
        wb_expected = 0;
        count_wb    = 1'b1;
        for (int i = 0; i < 16; i++) begin
            store_op(MEM_WORD, MIX_BASE + 4 * i, $urandom);
        end
        for (int i = 0; i < 40; i++) begin
            kind = $urandom_range(0, 2);
            sign = $urandom_range(0, 1);
            case ($urandom_range(0, 2))
                0: begin
                    sel  = MEM_BYTE;
                    addr = MIX_BASE + $urandom_range(0, 63);
                end
                1: begin
                    sel  = MEM_HALF;
                    addr = MIX_BASE + 2 * $urandom_range(0, 31);
                end
                default: begin
                    sel  = MEM_WORD;
                    addr = MIX_BASE + 4 * $urandom_range(0, 15);
                end
            endcase
            if (kind == 0) begin
                alu_op(random_rd(), $urandom);
            end else if (kind == 1) begin
                store_op(sel, addr, $urandom);
            end else begin
                load_op(sel, sign, random_rd(), addr, expected_load(addr, sel, sign));
            end
        end
        @(negedge clk);
        #1;
        count_wb = 1'b0;
        check_count("writebacks", wb_expected, wb_seen);
    endtask

    initial begin
        void'($urandom(SEED));
        rst         = 1'b1;
        rd_i        = NOP_REG_ADDR;
        wdata_i     = 32'h0;
        wreg_i      = 1'b0;
        pc_i        = 32'h0;
        reg2_i      = 32'h0;
        mem_addr_i  = 32'h0;
        alusel_i    = EXE_RES_NOP;
        mem_sel_i   = MEM_NOP;
        mem_we_i    = 1'b0;
        load_sign_i = 1'b0;
        next_pc     = 32'h0000_0100;
        test_name   = "init";
        value_errs  = 0;
        proto_errs  = 0;
        count_wb    = 1'b0;
        wb_seen     = 0;
        wb_expected = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_values();
        alu_passthrough();
        word_round_trip();
        store_isolation();
        load_extension();
        mixed_sequence();
        $display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
hdl/cpu_pkg.sv
hdl/mem_pkg.sv
hdl/mem_access.sv
hdl/byte_ram.sv
hdl/mem_wb_reg.sv
hdl/mem_stage_top.sv
sim/tb_mem_stage.sv
